// File: hdl/link_pkg.sv
package link_pkg;

	// One byte on the serial link.
	typedef logic [7:0] byte_t;

	// Command opcodes sent by the host.
	typedef enum byte_t {
		cmd_load_vector  = 8'h01,
		cmd_cycle_config = 8'h02,
		cmd_execute      = 8'h03
	} cmd_e;

	// Response codes returned to the host.
	typedef enum byte_t {
		resp_ack        = 8'hA5,
		resp_no_vectors = 8'hE1,
		resp_unknown    = 8'hEE
	} resp_e;

endpackage

// File: hdl/seq_pkg.sv
package seq_pkg;

	// Width of the leading edge, trailing edge and cycle length fields.
	parameter int TIME_W = 8;

	// Controller states.
	typedef enum logic [3:0] {
		st_idle,
		st_decode,
		st_prompt,
		st_prompt_wait,
		st_payload,
		st_store_vector,
		st_store_config,
		st_exec_start,
		st_exec_run,
		st_finish,
		st_send,
		st_send_wait
	} state_e;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic            CLK,
	input  logic            rst,
	input  logic            rx,
	output link_pkg::byte_t rx_data,
	output logic            rx_valid
);
	import link_pkg::*;

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data_bits,
		rx_stop
	} rx_state_e;

	rx_state_e     state;
	logic          rx_meta;
	logic          rx_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	byte_t         shift;

	assign rx_data = shift;

	// Two-flop synchronizer on the line.
	always_ff @(posedge CLK) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state    <= rx_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					if (!rx_sync) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					// Check again at the middle of the start bit.
					if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? rx_idle : rx_data_bits;
					end
				end
				rx_data_bits: begin
					if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						shift   <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end
				end
				rx_stop: begin
					// A low stop bit drops the frame.
					if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
						rx_valid <= rx_sync;
						state    <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic            CLK,
	input  logic            rst,
	input  logic            tx_start,
	input  link_pkg::byte_t tx_data,
	output logic            tx,
	output logic            tx_done
);
	import link_pkg::*;

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	logic          busy;
	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_idx;
	byte_t         shift;

	// Bit 0 is the start bit, 1 to 8 carry data, 9 is the stop bit.
	always_ff @(posedge CLK) begin
		if (rst) begin
			busy    <= 1'b0;
			tx      <= 1'b1;
			tx_done <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				if (tx_start) begin
					busy    <= 1'b1;
					tx      <= 1'b0;
					shift   <= tx_data;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
				clk_cnt <= '0;
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd9) begin
					busy    <= 1'b0;
					tx_done <= 1'b1;
				end else if (bit_idx == 4'd8) begin
					tx <= 1'b1;
				end else begin
					tx    <= shift[0];
					shift <= shift >> 1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

// File: hdl/vector_store.sv
`timescale 1ns/1ps

module vector_store #(
	parameter int VECTOR_WIDTH = 16,
	parameter int DEPTH        = 16
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    wr_en,
	input  logic [VECTOR_WIDTH-1:0] wr_data,
	input  logic                    next,
	input  logic                    clear,
	output logic [VECTOR_WIDTH-1:0] rd_data,
	output logic                    more
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int PW = $clog2(DEPTH + 1);

	logic [VECTOR_WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]           wr_ptr;
	logic [PW-1:0]           rd_ptr;
	logic                    full;
	logic                    do_write;

	assign full     = (wr_ptr == PW'(DEPTH));
	assign do_write = wr_en && !full;
	assign more     = (rd_ptr < wr_ptr);
	assign rd_data  = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge CLK) begin
		if (do_write) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	// Soft reset empties the store by rewinding both pointers.
	always_ff @(posedge CLK) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (next && more) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

// File: hdl/cycle_timer.sv
`timescale 1ns/1ps

module cycle_timer (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic                       run,
	input  logic [seq_pkg::TIME_W-1:0] leading_edge,
	input  logic [seq_pkg::TIME_W-1:0] trailing_edge,
	input  logic [seq_pkg::TIME_W-1:0] cycle_length,
	output logic                       strobe,
	output logic                       cycle_end
);
	import seq_pkg::*;

	logic [TIME_W-1:0] count;
	logic [TIME_W-1:0] count_nxt;
	logic              last;

	assign last      = (count == cycle_length - 1'b1);
	assign cycle_end = run && last;

	// Held at zero while idle, wraps at the end of each test cycle.
	always_comb begin
		if (!run || last) begin
			count_nxt = '0;
		end else begin
			count_nxt = count + 1'b1;
		end
	end

	// Strobe is computed from the next count so it lines up with count.
	always_ff @(posedge CLK) begin
		if (rst) begin
			count  <= '0;
			strobe <= 1'b0;
		end else begin
			count  <= count_nxt;
			strobe <= run && (count_nxt >= leading_edge) && (count_nxt < trailing_edge);
		end
	end

endmodule

// File: hdl/central_fsm.sv
`timescale 1ns/1ps

module central_fsm #(
	parameter int VECTOR_WIDTH = 16
) (
	input  logic                       CLK,
	input  logic                       rst,
	input  link_pkg::byte_t            rx_data,
	input  logic                       rx_valid,
	output link_pkg::byte_t            tx_data,
	output logic                       tx_start,
	input  logic                       tx_done,
	output logic                       wr_en,
	output logic [VECTOR_WIDTH-1:0]    wr_data,
	output logic                       next,
	output logic                       clear,
	input  logic [VECTOR_WIDTH-1:0]    rd_data,
	input  logic                       more,
	output logic                       run,
	output logic [seq_pkg::TIME_W-1:0] leading_edge,
	output logic [seq_pkg::TIME_W-1:0] trailing_edge,
	output logic [seq_pkg::TIME_W-1:0] cycle_length,
	input  logic                       cycle_end,
	output logic [VECTOR_WIDTH-1:0]    signals
);
	import link_pkg::*;
	import seq_pkg::*;

	localparam int VEC_BYTES = VECTOR_WIDTH / 8;
	localparam int CFG_W     = 3 * TIME_W;
	localparam int SR_W      = (VECTOR_WIDTH > CFG_W) ? VECTOR_WIDTH : CFG_W;
	localparam int CNT_W     = $clog2(SR_W / 8 + 1);

	state_e           state;
	logic             is_config;
	logic [CNT_W-1:0] bytes_left;
	logic [SR_W-1:0]  payload;

	assign tx_start = (state == st_prompt) || (state == st_send);
	assign wr_en    = (state == st_store_vector);
	assign wr_data  = payload[SR_W-1 -: VECTOR_WIDTH];
	assign clear    = (state == st_finish);
	assign next     = (state == st_exec_start) || (state == st_exec_run && cycle_end && more);

	// Payload bytes arrive LSB first and shift in from the top.
	always_ff @(posedge CLK) begin
		if (state == st_payload && rx_valid) begin
			payload <= {rx_data, payload[SR_W-1:8]};
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state         <= st_idle;
			is_config     <= 1'b0;
			bytes_left    <= '0;
			run           <= 1'b0;
			signals       <= '0;
			leading_edge  <= '0;
			trailing_edge <= '0;
			cycle_length  <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (rx_valid) begin
						state <= st_decode;
					end
				end
				st_decode: begin
					tx_data <= resp_ack;
					case (rx_data)
						cmd_load_vector: begin
							is_config  <= 1'b0;
							bytes_left <= CNT_W'(VEC_BYTES);
							state      <= st_prompt;
						end
						cmd_cycle_config: begin
							is_config  <= 1'b1;
							bytes_left <= CNT_W'(3);
							state      <= st_prompt;
						end
						cmd_execute: begin
							if (more) begin
								state <= st_exec_start;
							end else begin
								tx_data <= resp_no_vectors;
								state   <= st_send;
							end
						end
						default: begin
							tx_data <= resp_unknown;
							state   <= st_send;
						end
					endcase
				end

				////////////////////////////////////////
				// Payload reception.
				////////////////////////////////////////
				st_prompt: state <= st_prompt_wait;
				st_prompt_wait: begin
					if (tx_done) begin
						state <= st_payload;
					end
				end
				st_payload: begin
					if (rx_valid) begin
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == CNT_W'(1)) begin
							state <= is_config ? st_store_config : st_store_vector;
						end
					end
				end
				st_store_vector: begin
					tx_data <= resp_ack;
					state   <= st_send;
				end
				st_store_config: begin
					leading_edge  <= payload[SR_W-CFG_W +: TIME_W];
					trailing_edge <= payload[SR_W-CFG_W+TIME_W +: TIME_W];
					cycle_length  <= payload[SR_W-CFG_W+2*TIME_W +: TIME_W];
					tx_data       <= resp_ack;
					state         <= st_send;
				end

				////////////////////////////////////////
				// Test execution.
				////////////////////////////////////////
				st_exec_start: begin
					run     <= 1'b1;
					signals <= rd_data;
					state   <= st_exec_run;
				end
				st_exec_run: begin
					if (cycle_end) begin
						if (more) begin
							signals <= rd_data;
						end else begin
							run     <= 1'b0;
							signals <= '0;
							state   <= st_finish;
						end
					end
				end
				st_finish: begin
					// Store is cleared this cycle, then the host gets an ack.
					tx_data <= resp_ack;
					state   <= st_send;
				end

				st_send: state <= st_send_wait;
				st_send_wait: begin
					if (tx_done) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hdl/vector_sequencer.sv
`timescale 1ns/1ps

module vector_sequencer #(
	parameter int CLKS_PER_BIT = 16,
	parameter int VECTOR_WIDTH = 16,
	parameter int DEPTH        = 16
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    rx,
	output logic                    tx,
	output logic [VECTOR_WIDTH-1:0] signals,
	output logic                    strobe
);

	link_pkg::byte_t               rx_data;
	link_pkg::byte_t               tx_data;
	logic                          rx_valid;
	logic                          tx_start;
	logic                          tx_done;
	logic                          wr_en;
	logic [VECTOR_WIDTH-1:0]       wr_data;
	logic [VECTOR_WIDTH-1:0]       rd_data;
	logic                          next;
	logic                          clear;
	logic                          more;
	logic                          run;
	logic                          cycle_end;
	logic [seq_pkg::TIME_W-1:0]    leading_edge;
	logic [seq_pkg::TIME_W-1:0]    trailing_edge;
	logic [seq_pkg::TIME_W-1:0]    cycle_length;

	////////////////////////////////////////
	// Serial link.
	////////////////////////////////////////
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.CLK(CLK), .rst(rst), .rx(rx),
		.rx_data(rx_data), .rx_valid(rx_valid)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.CLK(CLK), .rst(rst), .tx_start(tx_start),
		.tx_data(tx_data), .tx(tx), .tx_done(tx_done)
	);

	////////////////////////////////////////
	// Storage, timing and control.
	////////////////////////////////////////
	vector_store #(.VECTOR_WIDTH(VECTOR_WIDTH), .DEPTH(DEPTH)) u_store (
		.CLK(CLK), .rst(rst), .wr_en(wr_en), .wr_data(wr_data),
		.next(next), .clear(clear), .rd_data(rd_data), .more(more)
	);

	cycle_timer u_timer (
		.CLK(CLK), .rst(rst), .run(run),
		.leading_edge(leading_edge), .trailing_edge(trailing_edge),
		.cycle_length(cycle_length), .strobe(strobe), .cycle_end(cycle_end)
	);

	central_fsm #(.VECTOR_WIDTH(VECTOR_WIDTH)) u_fsm (
		.CLK(CLK), .rst(rst),
		.rx_data(rx_data), .rx_valid(rx_valid),
		.tx_data(tx_data), .tx_start(tx_start), .tx_done(tx_done),
		.wr_en(wr_en), .wr_data(wr_data), .next(next), .clear(clear),
		.rd_data(rd_data), .more(more), .run(run),
		.leading_edge(leading_edge), .trailing_edge(trailing_edge),
		.cycle_length(cycle_length), .cycle_end(cycle_end), .signals(signals)
	);

endmodule

// File: test/vector_sequencer_tb.sv
`timescale 1ns/1ps

module vector_sequencer_tb;
	import link_pkg::*;

	localparam int CPB      = 4;
	localparam int VW       = 16;
	localparam int N_VEC    = 5;
	localparam int CYC_LEN  = 9;
	// Bytes on the link in both directions over all six tests.
	localparam int N_BYTES  = 39;
	localparam int LIMIT    = 2 * (N_BYTES * 10 * CPB + N_VEC * CYC_LEN);

	logic          CLK;
	logic          rst;
	logic          rx;
	logic          tx;
	logic [VW-1:0] signals;
	logic          strobe;

	logic [31:0]   lfsr;
	int            cycles;
	int            errors;
	int            tests_passed;
	int            tests_failed;
	logic [VW-1:0] model[$];

	// Pending comparisons for the checker to drain.
	string         name_q[$];
	logic [31:0]   exp_q[$];
	logic [31:0]   act_q[$];
	string         chk_name;
	logic [31:0]   chk_exp;
	logic [31:0]   chk_act;

	// Strobe monitor results.
	logic          prev_strobe;
	int            width;
	logic [VW-1:0] captured[$];
	int            widths[$];
	int            rises[$];

	vector_sequencer #(.CLKS_PER_BIT(CPB), .VECTOR_WIDTH(VW), .DEPTH(8)) DUT (
		.CLK(CLK), .rst(rst), .rx(rx), .tx(tx), .signals(signals), .strobe(strobe)
	);

	always #20 CLK = ~CLK;

	////////////////////////////////////////
	// Reference model and stimulus helpers.
	////////////////////////////////////////
	function automatic byte_t expected_response(input byte_t cmd, input int stored);
		case (cmd)
			cmd_load_vector, cmd_cycle_config: return resp_ack;
			cmd_execute: return (stored == 0) ? resp_no_vectors : resp_ack;
			default: return resp_unknown;
		endcase
	endfunction

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_vector(output logic [VW-1:0] v);
		int i;
		for (i = 0; i < VW; i++) begin
			lfsr = lfsr_step(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	task automatic expect_value(input string name, input logic [31:0] e, input logic [31:0] a);
		name_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(a);
	endtask

	// Each bit starts 2 ns after a rising edge and lasts CPB clocks.
	task automatic send_byte(input byte_t b);
		int i;
		@(posedge CLK);
		#2;
		rx = 1'b0;
		repeat (CPB) @(posedge CLK);
		#2;
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (CPB) @(posedge CLK);
			#2;
		end
		rx = 1'b1;
		repeat (CPB) @(posedge CLK);
		#2;
	endtask

	// Samples tx on falling edges near the middle of each bit.
	task automatic receive_byte(output byte_t b);
		int i;
		@(negedge CLK);
		while (tx !== 1'b0) @(negedge CLK);
		repeat (CPB / 2) @(negedge CLK);
		for (i = 0; i < 8; i++) begin
			repeat (CPB) @(negedge CLK);
			b[i] = tx;
		end
		repeat (CPB) @(negedge CLK);
		expect_value("stop_bit", 1, tx);
	endtask

	task automatic command_exchange(input byte_t cmd, input string name);
		byte_t r;
		send_byte(cmd);
		receive_byte(r);
		expect_value(name, expected_response(cmd, model.size()), r);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		repeat (2) @(negedge CLK);
		if (errors == start_errors) begin
			$display("PASS %s", name);
			tests_passed++;
		end else begin
			$display("FAIL %s", name);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////
	// Checker, monitor and timeout.
	////////////////////////////////////////
	always @(negedge CLK) begin
		while (exp_q.size() > 0) begin
			chk_name = name_q.pop_front();
			chk_exp  = exp_q.pop_front();
			chk_act  = act_q.pop_front();
			assert (chk_exp === chk_act) else begin
				$display("FAILED %s: expected %0h, actual %0h", chk_name, chk_exp, chk_act);
				errors++;
			end
		end
	end

	// Records signals and the cycle count at each strobe rise and the width of each pulse.
	always @(negedge CLK) begin
		if (strobe && !prev_strobe) begin
			captured.push_back(signals);
			rises.push_back(cycles);
			width = 1;
		end else if (strobe) begin
			width++;
		end else if (prev_strobe) begin
			widths.push_back(width);
		end
		prev_strobe = strobe;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the DUT did not finish within %0d cycles", LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////
	initial begin
		int            start;
		int            i;
		int            b;
		byte_t         r;
		logic [VW-1:0] v;
		CLK          = 1'b0;
		rst          = 1'b1;
		rx           = 1'b1;
		lfsr         = 32'h391c1295;
		cycles       = 0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		prev_strobe  = 1'b0;
		width        = 0;
		repeat (3) @(posedge CLK);
		#2;
		rst = 1'b0;

		start = errors;
		command_exchange(8'h7C, "unknown_command");
		finish_test("unknown_command", start);

		start = errors;
		command_exchange(cmd_execute, "execute_empty");
		finish_test("execute_empty", start);

		// Leading edge 2, trailing edge 5, cycle length 9.
		start = errors;
		command_exchange(cmd_cycle_config, "config_prompt");
		send_byte(8'd2);
		send_byte(8'd5);
		send_byte(8'(CYC_LEN));
		receive_byte(r);
		expect_value("config_ack", resp_ack, r);
		finish_test("cycle_config", start);

		start = errors;
		for (i = 0; i < N_VEC; i++) begin
			random_vector(v);
			command_exchange(cmd_load_vector, "load_prompt");
			for (b = 0; b < VW / 8; b++) begin
				send_byte(v[8*b +: 8]);
			end
			receive_byte(r);
			expect_value("load_ack", resp_ack, r);
			model.push_back(v);
		end
		finish_test("load_vectors", start);

		start = errors;
		captured.delete();
		widths.delete();
		rises.delete();
		command_exchange(cmd_execute, "execute_ack");
		expect_value("strobe_pulses", N_VEC, captured.size());
		expect_value("strobe_widths", N_VEC, widths.size());
		for (i = 0; i < N_VEC && i < captured.size(); i++) begin
			expect_value($sformatf("vector_%0d", i), model[i], captured[i]);
		end
		for (i = 0; i < widths.size(); i++) begin
			expect_value($sformatf("strobe_width_%0d", i), 3, widths[i]);
		end
		// Strobe rises once per test cycle.
		for (i = 1; i < rises.size(); i++) begin
			expect_value($sformatf("strobe_period_%0d", i), CYC_LEN, rises[i] - rises[i - 1]);
		end
		expect_value("signals_idle", 0, signals);
		// The soft reset empties the store.
		model.delete();
		finish_test("execute", start);

		start = errors;
		command_exchange(cmd_execute, "execute_after_clear");
		finish_test("execute_after_clear", start);

		$display("Tests: %0d passed, %0d failed, %0d check errors",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: sim.f
hdl/link_pkg.sv
hdl/seq_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/vector_store.sv
hdl/cycle_timer.sv
hdl/central_fsm.sv
hdl/vector_sequencer.sv
test/vector_sequencer_tb.sv
